//--- Makefile
TOOL     = verilator
FLAGS    = --binary -j 0
TOP      = tbTop
FILELIST = list.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJDIR)

//--- list.f
+incdir+logic
logic/cpuPkg.sv
logic/instrDecoder.sv
logic/dataUnit.sv
logic/programSequencer.sv
logic/memPort.sv
logic/cpuCore.sv
testbench/tbClock.sv
testbench/tbChecker.sv
testbench/tbTop.sv

//--- logic/cpuCore.sv
`timescale 1ns/1ns

module cpuCore (
    input  logic           clk,
    input  logic           rst,
    input  cpuPkg::instrT  instr,
    input  cpuPkg::byteT   rdData,
    output cpuPkg::addrT   instrAddr,
    output cpuPkg::memReqT memReq
);

    cpuPkg::decodeT dec;
    cpuPkg::byteT   storeData;
    cpuPkg::byteT   storeAddr;
    cpuPkg::flagsT  flags;
    cpuPkg::addrT   stackPtr;

    instrDecoder decoder0 (
        .instr (instr),
        .dec   (dec)
    );

    // registers, alu and flags
    dataUnit data0 (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec),
        .rdData    (rdData),
        .storeData (storeData),
        .storeAddr (storeAddr),
        .flags     (flags)
    );

    programSequencer seq0 (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec),
        .flags     (flags),
        .instrAddr (instrAddr),
        .stackPtr  (stackPtr)
    );

    memPort port0 (
        .rst       (rst),
        .dec       (dec),
        .storeData (storeData),
        .storeAddr (storeAddr),
        .stackPtr  (stackPtr),
        .instrAddr (instrAddr),
        .memReq    (memReq)
    );

endmodule

//--- logic/cpuPkg.sv
`include "cpu_settings.svh"

package cpuPkg;

    typedef logic [`DATA_WIDTH-1:0]       byteT;
    typedef logic [`ADDR_WIDTH-1:0]       addrT;
    typedef logic [$clog2(`NUM_REGS)-1:0] regSelT; // 0 selects r1

    // one fetched word
    typedef struct packed
    {
        byteT operand; // high byte
        byteT opcode;  // low byte
    } instrT;

    // low eight values line up with opcode bits 2:0
    typedef enum logic [3:0]
    {
        KIND_NOP  = 4'd0,
        KIND_MOV  = 4'd1,
        KIND_JMP  = 4'd2,
        KIND_LODB = 4'd3,
        KIND_STB  = 4'd4,
        KIND_BNE  = 4'd5,
        KIND_BEQ  = 4'd6,
        KIND_BGR  = 4'd7,
        KIND_ALU  = 4'd8,
        KIND_PUSH = 4'd9,
        KIND_POP  = 4'd10
    } instrKindE;

    typedef enum logic [3:0]
    {
        ALU_ADD = `ALU_OP_ADD,
        ALU_SUB = `ALU_OP_SUB,
        ALU_AND = `ALU_OP_AND,
        ALU_OR  = `ALU_OP_OR,
        ALU_CMP = `ALU_OP_CMP,
        ALU_XOR = `ALU_OP_XOR,
        ALU_SHL = `ALU_OP_SHL,
        ALU_SHR = `ALU_OP_SHR
    } aluOpE;

    // ----------------------------------------
    // decoded instruction
    // ----------------------------------------
    typedef struct packed
    {
        instrKindE kind;
        regSelT    srcSel;  // data / second alu operand
        regSelT    dstSel;  // register written
        regSelT    addrSel; // stb address register
        aluOpE     aluOp;
        byteT      operand;
    } decodeT;

    typedef struct packed
    {
        logic eq;
        logic gt;
    } flagsT;

    typedef struct packed
    {
        addrT addr;
        byteT wrData;
        logic wrEn;
    } memReqT;

endpackage

//--- logic/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath sizes
`define DATA_WIDTH 8
`define ADDR_WIDTH 16
`define NUM_REGS   4

`define STACK_TOP  {`ADDR_WIDTH{1'b1}} // stack grows down from here

// alu operation codes, taken from opcode bits 3:0
`define ALU_OP_ADD 4'd0
`define ALU_OP_SUB 4'd1
`define ALU_OP_AND 4'd2
`define ALU_OP_OR  4'd3
`define ALU_OP_CMP 4'd4
`define ALU_OP_XOR 4'd5
`define ALU_OP_SHL 4'd6
`define ALU_OP_SHR 4'd7

`endif

//--- logic/dataUnit.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module dataUnit (
    input  logic           clk,
    input  logic           rst,
    input  cpuPkg::decodeT dec,
    input  cpuPkg::byteT   rdData,
    output cpuPkg::byteT   storeData,
    output cpuPkg::byteT   storeAddr,
    output cpuPkg::flagsT  flags
);

    cpuPkg::byteT   regFile [`NUM_REGS]; // r1..r4
    cpuPkg::byteT   accVal;
    cpuPkg::byteT   srcVal;
    cpuPkg::byteT   aluResult;
    cpuPkg::flagsT  flagsQ;
    logic           isCmp;
    logic           regWrEn;
    cpuPkg::regSelT regWrSel;
    cpuPkg::byteT   regWrData;

    // ----------------------------------------
    // register reads
    // ----------------------------------------
    assign accVal    = regFile[0];
    assign srcVal    = regFile[dec.srcSel];
    assign storeData = srcVal;               // stb data and push data
    assign storeAddr = regFile[dec.addrSel];
    assign flags     = flagsQ;

    assign isCmp = (dec.kind == cpuPkg::KIND_ALU) && (dec.aluOp == cpuPkg::ALU_CMP);

    // ----------------------------------------
    // alu
    // ----------------------------------------
    always_comb
    begin
        case (dec.aluOp)
            cpuPkg::ALU_ADD: aluResult = accVal + srcVal;
            cpuPkg::ALU_SUB: aluResult = accVal - srcVal;
            cpuPkg::ALU_AND: aluResult = accVal & srcVal;
            cpuPkg::ALU_OR:  aluResult = accVal | srcVal;
            cpuPkg::ALU_CMP: aluResult = accVal - srcVal; // never written back
            cpuPkg::ALU_XOR: aluResult = accVal ^ srcVal;
            cpuPkg::ALU_SHL: aluResult = accVal << srcVal;
            cpuPkg::ALU_SHR: aluResult = accVal >> srcVal;
            default:         aluResult = srcVal; // codes 8..15
        endcase
    end

    // pick the one register write of this cycle
    always_comb
    begin
        regWrEn   = 1'b0;
        regWrSel  = dec.dstSel;
        regWrData = aluResult;
        case (dec.kind)
            cpuPkg::KIND_ALU:
            begin
                regWrEn  = !isCmp;
                regWrSel = '0; // result always goes to r1
            end
            cpuPkg::KIND_MOV:
            begin
                regWrEn   = 1'b1;
                regWrData = srcVal;
            end
            cpuPkg::KIND_LODB:
            begin
                regWrEn   = 1'b1;
                regWrData = dec.operand;
            end
            cpuPkg::KIND_POP:
            begin
                regWrEn   = 1'b1;
                regWrData = rdData; // byte read at sp + 1
            end
            default:
                regWrEn = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `NUM_REGS; i++)
            begin
                regFile[i] <= '0;
            end
            flagsQ <= '0;
        end
        else
        begin
            if (regWrEn)
            begin
                regFile[regWrSel] <= regWrData;
            end
            // flags only change on cmp
            if (isCmp)
            begin
                flagsQ.eq <= (accVal == srcVal);
                flagsQ.gt <= (accVal > srcVal);
            end
        end
    end

endmodule

//--- logic/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder (
    input  cpuPkg::instrT  instr,
    output cpuPkg::decodeT dec
);

    cpuPkg::byteT op;

    assign op = instr.opcode;

    always_comb
    begin
        // defaults follow the regular opcode layout
        dec.kind    = cpuPkg::KIND_NOP;
        dec.srcSel  = op[4:3];
        dec.dstSel  = op[6:5];
        dec.addrSel = op[6:5];
        dec.aluOp   = cpuPkg::aluOpE'(op[3:0]);
        dec.operand = instr.operand;

        if (op[7])
        begin
            dec.kind   = cpuPkg::KIND_ALU;
            dec.srcSel = op[6:5]; // r1 is always the other operand
        end
        else if (op[3:0] == 4'b1111)
        begin
            // stack ops name a single register in 6:5
            if (op[4])
            begin
                dec.kind = cpuPkg::KIND_POP;
            end
            else
            begin
                dec.kind = cpuPkg::KIND_PUSH;
            end
            dec.srcSel = op[6:5];
            dec.dstSel = op[6:5];
        end
        else
        begin
            // regular opcodes
            case (op[2:0])
                3'b000:
                    dec.kind = cpuPkg::KIND_NOP;
                3'b001:
                    dec.kind = cpuPkg::KIND_MOV;
                3'b010:
                    dec.kind = cpuPkg::KIND_JMP;
                3'b011:
                begin
                    dec.kind   = cpuPkg::KIND_LODB;
                    dec.dstSel = op[4:3]; // lodb target sits lower
                end
                3'b100:
                    dec.kind = cpuPkg::KIND_STB;
                3'b101:
                    dec.kind = cpuPkg::KIND_BNE;
                3'b110:
                    dec.kind = cpuPkg::KIND_BEQ;
                default:
                    dec.kind = cpuPkg::KIND_BGR; // old lodbmem codes land here too
            endcase
        end
    end

endmodule

//--- logic/memPort.sv
`timescale 1ns/1ns

module memPort (
    input  logic           rst,
    input  cpuPkg::decodeT dec,
    input  cpuPkg::byteT   storeData,
    input  cpuPkg::byteT   storeAddr,
    input  cpuPkg::addrT   stackPtr,
    input  cpuPkg::addrT   instrAddr,
    output cpuPkg::memReqT memReq
);

    always_comb
    begin
        memReq.wrData = storeData;
        memReq.wrEn   = 1'b0;
        case (dec.kind)
            cpuPkg::KIND_STB:
            begin
                memReq.addr = cpuPkg::addrT'(storeAddr); // low page only
                memReq.wrEn = !rst;
            end
            cpuPkg::KIND_PUSH:
            begin
                memReq.addr = stackPtr;
                memReq.wrEn = !rst;
            end
            cpuPkg::KIND_POP:
                memReq.addr = stackPtr + cpuPkg::addrT'(1); // last pushed byte
            default:
                memReq.addr = instrAddr + cpuPkg::addrT'(1);
        endcase
    end

endmodule

//--- logic/programSequencer.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module programSequencer (
    input  logic           clk,
    input  logic           rst,
    input  cpuPkg::decodeT dec,
    input  cpuPkg::flagsT  flags,
    output cpuPkg::addrT   instrAddr,
    output cpuPkg::addrT   stackPtr
);

    cpuPkg::addrT pcQ;
    cpuPkg::addrT pcNext;
    cpuPkg::addrT spQ;
    cpuPkg::addrT spNext;
    cpuPkg::addrT jmpOffset;
    logic         branchTaken;

    // relative jump distance, two's complement byte
    assign jmpOffset = {{(`ADDR_WIDTH-`DATA_WIDTH){dec.operand[`DATA_WIDTH-1]}}, dec.operand};

    always_comb
    begin
        case (dec.kind)
            cpuPkg::KIND_BNE: branchTaken = !flags.eq;
            cpuPkg::KIND_BEQ: branchTaken = flags.eq;
            cpuPkg::KIND_BGR: branchTaken = flags.gt;
            default:          branchTaken = 1'b0;
        endcase
    end

    // ----------------------------------------
    // next pc and stack pointer
    // ----------------------------------------
    always_comb
    begin
        case (dec.kind)
            cpuPkg::KIND_LODB:
                pcNext = pcQ + cpuPkg::addrT'(2);
            cpuPkg::KIND_JMP:
                pcNext = pcQ + jmpOffset;
            cpuPkg::KIND_BNE, cpuPkg::KIND_BEQ, cpuPkg::KIND_BGR:
                pcNext = branchTaken ? cpuPkg::addrT'(dec.operand) // absolute target
                                     : pcQ + cpuPkg::addrT'(2);
            default:
                pcNext = pcQ + cpuPkg::addrT'(1);
        endcase

        case (dec.kind)
            cpuPkg::KIND_PUSH: spNext = spQ - cpuPkg::addrT'(1);
            cpuPkg::KIND_POP:  spNext = spQ + cpuPkg::addrT'(1);
            default:           spNext = spQ;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pcQ <= '0;
            spQ <= `STACK_TOP;
        end
        else
        begin
            pcQ <= pcNext;
            spQ <= spNext;
        end
    end

    assign instrAddr = pcQ;
    assign stackPtr  = spQ;

endmodule

//--- testbench/tbChecker.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module tbChecker (
    input  logic           clk,
    input  logic           rst,
    input  cpuPkg::instrT  instr,
    input  cpuPkg::byteT   rdData,
    input  cpuPkg::addrT   instrAddr,
    input  cpuPkg::memReqT memReq,
    output int             checkCount,
    output int             pcErrors,
    output int             addrErrors,
    output int             dataErrors,
    output int             wrEnErrors
);

    cpuPkg::byteT regs [`NUM_REGS]; // r1 at index 0
    logic         eqFlag;
    logic         gtFlag;
    cpuPkg::addrT pc;
    cpuPkg::addrT sp;

    function automatic cpuPkg::byteT aluModel(input logic [3:0] code, input cpuPkg::byteT a,
                                              input cpuPkg::byteT b);
        case (code)
            `ALU_OP_ADD: return a + b;
            `ALU_OP_SUB: return a - b;
            `ALU_OP_AND: return a & b;
            `ALU_OP_OR:  return a | b;
            `ALU_OP_XOR: return a ^ b;
            `ALU_OP_SHL: return a << b;
            `ALU_OP_SHR: return a >> b;
            default:     return b; // pass-through codes
        endcase
    endfunction

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] expected, inout int counter);
        if (got !== expected)
        begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h (t=%0t)", name, got, expected, $time);
            counter++;
        end
    endtask

    // ----------------------------------------
    // one instruction checked per cycle
    // ----------------------------------------
    task automatic checkCycle();
        cpuPkg::byteT   op;
        cpuPkg::byteT   opnd;
        logic [1:0]     hiSel;
        logic [1:0]     loSel;
        cpuPkg::addrT   nextPc;
        cpuPkg::memReqT want;
        op     = instr.opcode;
        opnd   = instr.operand;
        hiSel  = op[6:5];
        loSel  = op[4:3];
        checkCount++;
        if (rst)
        begin
            regs   = '{default: '0};
            eqFlag = 1'b0;
            gtFlag = 1'b0;
            pc     = '0;
            sp     = `STACK_TOP;
            compareValue("instrAddr", 32'(instrAddr), 32'(pc), pcErrors);
            compareValue("memReq.wrEn", 32'(memReq.wrEn), 32'(0), wrEnErrors);
        end
        else
        begin
            nextPc = pc + 16'd1;
            want   = '{addr: pc + 16'd1, wrData: 8'h00, wrEn: 1'b0};
            if (op[7])
            begin
                if (op[3:0] == `ALU_OP_CMP)
                begin
                    eqFlag = (regs[0] == regs[hiSel]);
                    gtFlag = (regs[0] > regs[hiSel]);
                end
                else
                    regs[0] = aluModel(op[3:0], regs[0], regs[hiSel]);
            end
            else if (op[3:0] == 4'hf)
            begin
                if (op[4])
                begin
                    want.addr   = sp + 16'd1; // last pushed slot
                    regs[hiSel] = rdData;
                    sp          = sp + 16'd1;
                end
                else
                begin
                    want = '{addr: sp, wrData: regs[hiSel], wrEn: 1'b1};
                    sp   = sp - 16'd1;
                end
            end
            else
            begin
                case (op[2:0])
                    3'd1: regs[hiSel] = regs[loSel];               // mov
                    3'd2: nextPc = pc + {{8{opnd[7]}}, opnd};      // relative jmp
                    3'd3:
                    begin
                        regs[loSel] = opnd;
                        nextPc      = pc + 16'd2;
                    end
                    3'd4: want = '{addr: {8'h00, regs[hiSel]}, wrData: regs[loSel], wrEn: 1'b1};
                    3'd5: nextPc = !eqFlag ? {8'h00, opnd} : pc + 16'd2;
                    3'd6: nextPc = eqFlag ? {8'h00, opnd} : pc + 16'd2;
                    3'd7: nextPc = gtFlag ? {8'h00, opnd} : pc + 16'd2;
                    default: nextPc = pc + 16'd1;                // nop
                endcase
            end
            compareValue("instrAddr", 32'(instrAddr), 32'(pc), pcErrors);
            compareValue("memReq.addr", 32'(memReq.addr), 32'(want.addr), addrErrors);
            compareValue("memReq.wrEn", 32'(memReq.wrEn), 32'(want.wrEn), wrEnErrors);
            if (want.wrEn)
                compareValue("memReq.wrData", 32'(memReq.wrData), 32'(want.wrData), dataErrors);
            pc = nextPc;
        end
    endtask

    initial
    begin
        checkCount = 0;
        pcErrors   = 0;
        addrErrors = 0;
        dataErrors = 0;
        wrEnErrors = 0;
        @(posedge clk); // reset is already high here
        forever
        begin
            @(negedge clk); // mid-cycle, inputs settled
            checkCycle();
        end
    end

endmodule

//--- testbench/tbClock.sv
`timescale 1ns/1ns

module tbClock #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release just after an edge, in step with the stimulus
    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

//--- testbench/tbTop.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module tbTop;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_CYCLES   = 2000;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_CYCLES + 20) * CLK_PERIOD;

    logic           clk;
    logic           rst;
    cpuPkg::instrT  instr;
    cpuPkg::byteT   rdData;
    cpuPkg::addrT   instrAddr;
    cpuPkg::memReqT memReq;
    int             seed;
    int             checkCount;
    int             pcErrors;
    int             addrErrors;
    int             dataErrors;
    int             wrEnErrors;
    int             totalErrors;

    tbClock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock0 (.*);

    cpuCore dut0 (.*);

    tbChecker checker0 (.*);

    // cmp and branches weighted up so the flags get exercised
    task automatic drawInstr(output cpuPkg::instrT word, output cpuPkg::byteT data);
        int          pick;
        logic [31:0] bits;
        logic [2:0]  brKind;
        pick   = int'(($random(seed) & 32'h7fff_ffff) % 100);
        bits   = $random(seed);
        brKind = (bits[17:16] == 2'd0) ? 3'd5 : (bits[17:16] == 2'd1) ? 3'd6 : 3'd7;
        word.operand = bits[15:8];
        data         = bits[31:24];
        if (pick < 30)
            word.opcode = {1'b1, bits[6:4], `ALU_OP_CMP};
        else if (pick < 48)
            word.opcode = {1'b0, bits[6:4], 1'b0, brKind}; // bit 3 low keeps it off push/pop
        else if (pick < 56)
            word.opcode = {1'b0, bits[6:3], 3'b011};       // lodb
        else if (pick < 62)
            word.opcode = {1'b0, bits[6:3], 3'b010};       // jmp
        else if (pick < 70)
            word.opcode = {1'b0, bits[6:3], 3'b100};       // stb
        else if (pick < 80)
            word.opcode = {1'b0, bits[6:4], 4'hf};
        else if (pick < 90)
            word.opcode = {1'b1, bits[6:0]};
        else
            word.opcode = bits[7:0];
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial
    begin
        seed   = 83607;
        instr  = '{operand: 8'h00, opcode: 8'h0f}; // push r1, held through reset
        rdData = '0;
        @(negedge rst);
        for (int n = 1; n < NUM_CYCLES; n++)
        begin
            @(posedge clk);
            #1;
            drawInstr(instr, rdData);
        end
        repeat (2) @(posedge clk);
        totalErrors = pcErrors + addrErrors + dataErrors + wrEnErrors;
        $display("checked %0d cycles, errors: instrAddr %0d addr %0d wrData %0d wrEn %0d",
                 checkCount, pcErrors, addrErrors, dataErrors, wrEnErrors);
        if (checkCount == 0)
            $display("the checker never compared a cycle");
        if (totalErrors == 0 && checkCount > 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog
    initial
    begin
        #(TIMEOUT_NS);
        $display("run did not finish within %0d ns, stimulus looks stuck", TIMEOUT_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule
